//--- common/mem_pkg.sv
// shared constants for the cached data memory subsystem
// address field split, cache geometry, bank timing and the
// controller state encoding; referenced as mem_pkg::name everywhere
`default_nettype none

package mem_pkg;

   // byte address and data word
   localparam int addr_w = 16;
   localparam int data_w = 16;

   // address fields: tag [15:11], index [10:3], word offset [2:1], byte bit [0]
   localparam int tag_w    = 5;
   localparam int index_w  = 8;
   localparam int offset_w = 2;

   // cache geometry
   localparam int words_per_line = 4;
   localparam int num_lines      = 256;
   localparam logic [offset_w-1:0] last_word = offset_w'(words_per_line - 1);

   // banked main memory, bank picked by the word offset
   localparam int num_banks   = 4;
   localparam int bank_depth  = 8192;
   localparam int bank_addr_w = $clog2(bank_depth);

   // memory timing
   localparam int mem_read_lat     = 2;  // rd strobe to data_out
   localparam int bank_busy_cycles = 4;  // busy time after any access
   localparam int busy_cnt_w       = $clog2(bank_busy_cycles + 1);
   localparam logic [busy_cnt_w-1:0] busy_load = busy_cnt_w'(bank_busy_cycles);

   // miss handling states
   typedef enum logic [2:0] {
      idle_cmp,    // compare against the request
      wb_issue,    // write back dirty victim
      fill_issue,  // issue line reads
      fill_wait,   // drain returning words
      final_cmp    // compare again and complete
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- cache/cache_array.sv
// direct-mapped cache storage: per-line tag, valid and dirty plus four words
// lookup of the indexed line is combinational, writes land on the rising edge
// compare mode checks the tag and only writes on a hit, marking the line dirty
// access mode stores word, tag and valid_in unconditionally and cleans the line
`timescale 1ns/1ns
`default_nettype none

module cache_array (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         enable,
   input  logic                         comp,
   input  logic                         write,
   input  logic                         valid_in,
   input  logic [mem_pkg::tag_w-1:0]    tag_in,
   input  logic [mem_pkg::index_w-1:0]  index,
   input  logic [mem_pkg::offset_w-1:0] offset,
   input  logic [mem_pkg::data_w-1:0]   data_in,
   output logic [mem_pkg::tag_w-1:0]    tag_out,
   output logic [mem_pkg::data_w-1:0]   data_out,
   output logic                         hit,
   output logic                         valid,
   output logic                         dirty
);

   logic [mem_pkg::tag_w-1:0]  tag_mem  [mem_pkg::num_lines];
   logic [mem_pkg::data_w-1:0] data_mem [mem_pkg::num_lines][mem_pkg::words_per_line];
   logic [mem_pkg::num_lines-1:0] valid_q;
   logic [mem_pkg::num_lines-1:0] dirty_q;

   logic wr_cmp;  // write hit in compare mode
   logic wr_acc;  // fill style write

   // lookup of the addressed line
   assign tag_out  = tag_mem[index];
   assign data_out = data_mem[index][offset];
   assign valid    = valid_q[index];
   assign dirty    = dirty_q[index];
   assign hit      = enable & (tag_out == tag_in);

   assign wr_cmp = enable & write & comp & hit & valid;
   assign wr_acc = enable & write & ~comp;

   // line status bits
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (wr_acc) begin
         valid_q[index] <= valid_in;
         dirty_q[index] <= 1'b0;  // freshly filled from memory
      end else if (wr_cmp) begin
         dirty_q[index] <= 1'b1;
      end
   end

   // tag and word storage
   always_ff @(posedge clk) begin
      if (wr_acc) begin
         tag_mem[index]          <= tag_in;
         data_mem[index][offset] <= data_in;
      end else if (wr_cmp) begin
         data_mem[index][offset] <= data_in;
      end
   end

endmodule

`default_nettype wire

//--- cache/cache_ctrl.sv
// miss handling FSM for the direct-mapped cache
// a hit completes in idle_cmp; a miss writes back a dirty victim, issues the
// line fill and writes each returning word when it arrives from memory,
// then repeats the compare in final_cmp to complete the request
// memory stall holds state, offset and strobe until the bank frees up
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         rd,
   input  logic                         wr,
   input  logic                         req_ok,
   input  logic                         hit,
   input  logic                         valid,
   input  logic                         dirty,
   input  logic                         m_stall,
   output logic                         stall,
   output logic                         done,
   output logic                         can_hit,
   output logic                         c_en,
   output logic                         c_comp,
   output logic                         c_write,
   output logic                         c_valid_in,
   output logic [mem_pkg::offset_w-1:0] c_offset,
   output logic                         m_rd,
   output logic                         m_wr,
   output logic [mem_pkg::offset_w-1:0] m_offset
);

   mem_pkg::ctrl_state_t state;
   mem_pkg::ctrl_state_t state_nxt;

   logic [mem_pkg::offset_w-1:0] issue_cnt;  // word being written back or fetched
   logic                         issue_go;   // strobe accepted this cycle
   logic                         line_hit;
   logic                         miss;

   // outstanding fill reads, stage 0 newest
   logic [mem_pkg::mem_read_lat-1:0] ret_valid;
   logic [mem_pkg::offset_w-1:0]     ret_off [mem_pkg::mem_read_lat];
   logic                             ret_now;
   logic [mem_pkg::offset_w-1:0]     ret_now_off;

   assign line_hit    = hit & valid;
   assign miss        = (rd | wr) & req_ok & ~line_hit;
   assign issue_go    = (m_rd | m_wr) & ~m_stall;
   assign ret_now     = ret_valid[mem_pkg::mem_read_lat-1];  // word on memory data_out
   assign ret_now_off = ret_off[mem_pkg::mem_read_lat-1];
   assign m_offset    = issue_cnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= mem_pkg::idle_cmp;
         issue_cnt <= '0;
         ret_valid <= '0;
      end else begin
         state <= state_nxt;
         if (issue_go)
            issue_cnt <= issue_cnt + 1'b1;  // wraps to 0 after the last word
         ret_valid <= {ret_valid[mem_pkg::mem_read_lat-2:0], m_rd & ~m_stall};
      end
   end

   // offsets ride along with their valid bits
   always_ff @(posedge clk) begin
      ret_off[0] <= issue_cnt;
      for (int i = 1; i < mem_pkg::mem_read_lat; i++) begin
         ret_off[i] <= ret_off[i-1];
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         mem_pkg::idle_cmp: begin
            if (miss) begin
               if (valid & dirty)
                  state_nxt = mem_pkg::wb_issue;
               else
                  state_nxt = mem_pkg::fill_issue;
            end
         end
         mem_pkg::wb_issue: begin
            if (issue_go && issue_cnt == mem_pkg::last_word)
               state_nxt = mem_pkg::fill_issue;
         end
         mem_pkg::fill_issue: begin
            if (issue_go && issue_cnt == mem_pkg::last_word)
               state_nxt = mem_pkg::fill_wait;
         end
         mem_pkg::fill_wait: begin
            // leave once only the oldest read is still pending
            if (ret_valid[mem_pkg::mem_read_lat-2:0] == '0)
               state_nxt = mem_pkg::final_cmp;
         end
         mem_pkg::final_cmp: state_nxt = mem_pkg::idle_cmp;
         default:            state_nxt = mem_pkg::idle_cmp;
      endcase
   end

   always_comb begin
      stall      = 1'b0;
      done       = 1'b0;
      can_hit    = 1'b0;
      c_en       = 1'b1;
      c_comp     = 1'b0;
      c_write    = ret_now;  // store returning fill word
      c_valid_in = ret_now;
      c_offset   = ret_now ? ret_now_off : issue_cnt;
      m_rd       = 1'b0;
      m_wr       = 1'b0;
      case (state)
         mem_pkg::idle_cmp: begin
            can_hit = 1'b1;
            c_en    = rd | wr;
            c_comp  = 1'b1;
            c_write = wr & req_ok;  // array drops it on a miss
            done    = req_ok & line_hit;
         end
         mem_pkg::wb_issue: begin
            stall = 1'b1;
            m_wr  = 1'b1;
         end
         mem_pkg::fill_issue: begin
            stall = 1'b1;
            m_rd  = 1'b1;
         end
         mem_pkg::fill_wait: begin
            stall = 1'b1;
         end
         mem_pkg::final_cmp: begin
            c_comp  = 1'b1;
            c_write = wr & req_ok;
            done    = req_ok & line_hit;
         end
         default: begin
            stall = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- memory/four_bank_mem.sv
// banked main memory behind the cache
// four word-interleaved banks selected by address bits 2:1
// an access to a bank that is still busy raises stall in the same cycle and
// is dropped; an accepted read returns mem_read_lat cycles later through a
// delay line, so reads to different banks overlap
`timescale 1ns/1ns
`default_nettype none

module four_bank_mem (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       rd,
   input  logic                       wr,
   input  logic [mem_pkg::addr_w-1:0] addr,
   input  logic [mem_pkg::data_w-1:0] data_in,
   output logic [mem_pkg::data_w-1:0] data_out,
   output logic                       stall
);

   logic [mem_pkg::data_w-1:0] bank_mem [mem_pkg::num_banks][mem_pkg::bank_depth];
   logic [mem_pkg::busy_cnt_w-1:0] busy_cnt [mem_pkg::num_banks];
   logic [mem_pkg::data_w-1:0] rd_pipe [mem_pkg::mem_read_lat];

   logic [mem_pkg::offset_w-1:0]    bank_sel;
   logic [mem_pkg::bank_addr_w-1:0] word_sel;
   logic                            accept;

   assign bank_sel = addr[1 +: mem_pkg::offset_w];
   assign word_sel = addr[mem_pkg::offset_w+1 +: mem_pkg::bank_addr_w];
   assign stall    = (rd | wr) & (busy_cnt[bank_sel] != '0);
   assign accept   = (rd | wr) & ~stall;
   assign data_out = rd_pipe[mem_pkg::mem_read_lat-1];

   // banks power up cleared
   initial begin
      for (int b = 0; b < mem_pkg::num_banks; b++) begin
         for (int w = 0; w < mem_pkg::bank_depth; w++) begin
            bank_mem[b][w] = '0;
         end
      end
   end

   always @(posedge clk) begin
      if (wr && accept)
         bank_mem[bank_sel][word_sel] <= data_in;
   end

   // read delay line
   always_ff @(posedge clk) begin
      rd_pipe[0] <= (rd && accept) ? bank_mem[bank_sel][word_sel] : '0;
      for (int i = 1; i < mem_pkg::mem_read_lat; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   // per-bank busy countdown
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int b = 0; b < mem_pkg::num_banks; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < mem_pkg::num_banks; b++) begin
            if (accept && bank_sel == b)
               busy_cnt[b] <= mem_pkg::busy_load;
            else if (busy_cnt[b] != '0)
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/mem_system.sv
// data memory subsystem top: requester port, cache array, miss controller
// and banked memory
// the requester holds rd or wr, addr and data_in until done; odd addresses
// and rd with wr together raise err and are never served
`timescale 1ns/1ns
`default_nettype none

module mem_system (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       rd,
   input  logic                       wr,
   input  logic [mem_pkg::addr_w-1:0] addr,
   input  logic [mem_pkg::data_w-1:0] data_in,
   output logic [mem_pkg::data_w-1:0] data_out,
   output logic                       done,
   output logic                       stall,
   output logic                       cache_hit,
   output logic                       err
);

   logic                         req_ok;
   logic                         can_hit;

   // cache array side
   logic                         c_en;
   logic                         c_comp;
   logic                         c_write;
   logic                         c_valid_in;
   logic [mem_pkg::offset_w-1:0] c_offset;
   logic [mem_pkg::offset_w-1:0] c_word;
   logic [mem_pkg::data_w-1:0]   c_data_in;
   logic [mem_pkg::tag_w-1:0]    c_tag_out;
   logic [mem_pkg::data_w-1:0]   c_data_out;
   logic                         c_hit;
   logic                         c_valid;
   logic                         c_dirty;

   // memory side
   logic                         m_rd;
   logic                         m_wr;
   logic                         m_stall;
   logic [mem_pkg::offset_w-1:0] m_offset;
   logic [mem_pkg::addr_w-1:0]   m_addr;
   logic [mem_pkg::data_w-1:0]   m_data_out;

   assign req_ok = (rd ^ wr) & ~addr[0];
   assign err    = (rd | wr) & ~req_ok;

   // compare mode uses the request word, fills use the controller offset
   assign c_word    = c_comp ? addr[1 +: mem_pkg::offset_w] : c_offset;
   assign c_data_in = c_comp ? data_in : m_data_out;

   // write-back goes to the victim's tag, fills fetch the request tag
   assign m_addr = m_wr ?
      {c_tag_out, addr[mem_pkg::offset_w+1 +: mem_pkg::index_w], m_offset, 1'b0} :
      {addr[mem_pkg::addr_w-1:mem_pkg::offset_w+1], m_offset, 1'b0};

   assign data_out  = c_data_out;
   assign cache_hit = done & can_hit;  // final_cmp completions are misses

   cache_array u_cache (
      .clk      (clk),
      .rst_n    (rst_n),
      .enable   (c_en),
      .comp     (c_comp),
      .write    (c_write),
      .valid_in (c_valid_in),
      .tag_in   (addr[mem_pkg::addr_w-1 -: mem_pkg::tag_w]),
      .index    (addr[mem_pkg::offset_w+1 +: mem_pkg::index_w]),
      .offset   (c_word),
      .data_in  (c_data_in),
      .tag_out  (c_tag_out),
      .data_out (c_data_out),
      .hit      (c_hit),
      .valid    (c_valid),
      .dirty    (c_dirty)
   );

   cache_ctrl u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .rd         (rd),
      .wr         (wr),
      .req_ok     (req_ok),
      .hit        (c_hit),
      .valid      (c_valid),
      .dirty      (c_dirty),
      .m_stall    (m_stall),
      .stall      (stall),
      .done       (done),
      .can_hit    (can_hit),
      .c_en       (c_en),
      .c_comp     (c_comp),
      .c_write    (c_write),
      .c_valid_in (c_valid_in),
      .c_offset   (c_offset),
      .m_rd       (m_rd),
      .m_wr       (m_wr),
      .m_offset   (m_offset)
   );

   four_bank_mem u_mem (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd       (m_rd),
      .wr       (m_wr),
      .addr     (m_addr),
      .data_in  (c_data_out),  // victim word during write-back
      .data_out (m_data_out),
      .stall    (m_stall)
   );

endmodule

`default_nettype wire

//--- bench/mem_system_checker.sv
// concurrent assertions on the requester handshake and memory strobes
// attached to mem_system through the bind at the bottom
`timescale 1ns/1ns
`default_nettype none

module mem_system_checker (
   input logic clk,
   input logic rst_n,
   input logic rd,
   input logic wr,
   input logic done,
   input logic stall,
   input logic err,
   input logic m_rd,
   input logic m_wr
);

   // done ends a miss, never overlaps its stall
   done_stall_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(done && stall))
      else $error("done and stall high in the same cycle");

   // a stall only follows a request
   stall_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      stall |-> $past(rd || wr))
      else $error("stall raised without a preceding request");

   mem_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(m_rd && m_wr))
      else $error("memory read and write strobes high together");

   // illegal requests are never served
   err_no_done: assert property (@(posedge clk) disable iff (!rst_n)
      !(err && done))
      else $error("done raised for an illegal request");

endmodule

bind mem_system mem_system_checker u_checker (
   .clk   (clk),
   .rst_n (rst_n),
   .rd    (rd),
   .wr    (wr),
   .done  (done),
   .stall (stall),
   .err   (err),
   .m_rd  (m_rd),
   .m_wr  (m_wr)
);

`default_nettype wire

//--- bench/mem_system_tb.sv
// testbench for the cached data memory subsystem
// applies a directed operation table, then a seeded random mix of reads and
// writes; expected data comes from a shadow word memory and expected hits
// from a shadow tag/valid array following the direct-mapped placement
`timescale 1ns/1ns
`default_nettype none

module mem_system_tb;

   localparam int clk_period    = 20;
   localparam int drive_delay   = 2;
   localparam int reset_cycles  = 8;
   localparam int n_random      = 200;
   localparam int cycles_per_op = 40;

   typedef enum logic [1:0] {op_rd, op_wr, op_bad} op_kind_t;

   logic        clk;
   logic        rst_n;
   logic        rd;
   logic        wr;
   logic [15:0] addr;
   logic [15:0] data_in;
   logic [15:0] data_out;
   logic        done;
   logic        stall;
   logic        cache_hit;
   logic        err;

   // operation table
   op_kind_t    tbl_kind [$];
   logic [15:0] tbl_addr [$];
   logic [15:0] tbl_data [$];
   logic        table_ready;

   // shadow models
   logic [15:0] shadow_mem [0:32767];  // by word address
   logic [4:0]  shadow_tag [0:255];
   logic        shadow_valid [0:255];

   int     errors;
   int     checks;
   integer seed;

   mem_system dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd        (rd),
      .wr        (wr),
      .addr      (addr),
      .data_in   (data_in),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #(clk_period / 2) clk = ~clk;

   function automatic logic [15:0] make_addr(input logic [4:0] tag, input logic [7:0] index,
                                             input logic [1:0] word);
      return {tag, index, word, 1'b0};
   endfunction

   task automatic add_op(input op_kind_t kind, input logic [15:0] a, input logic [15:0] d);
      tbl_kind.push_back(kind);
      tbl_addr.push_back(a);
      tbl_data.push_back(d);
   endtask

   task automatic build_table();
      add_op(op_rd, make_addr(5'd1, 8'd5, 2'd0), 16'h0000);   // cold miss
      add_op(op_wr, make_addr(5'd1, 8'd5, 2'd1), 16'ha5a5);   // write hit
      add_op(op_rd, make_addr(5'd1, 8'd5, 2'd1), 16'h0000);
      add_op(op_rd, make_addr(5'd1, 8'd5, 2'd3), 16'h0000);   // other word, same line
      add_op(op_wr, make_addr(5'd2, 8'd9, 2'd2), 16'h1234);   // write allocate
      add_op(op_rd, make_addr(5'd2, 8'd9, 2'd2), 16'h0000);
      add_op(op_rd, make_addr(5'd7, 8'd9, 2'd2), 16'h0000);   // evicts dirty line
      add_op(op_rd, make_addr(5'd2, 8'd9, 2'd2), 16'h0000);   // back from memory
      add_op(op_wr, make_addr(5'd3, 8'd5, 2'd0), 16'hbeef);   // dirty conflict on write
      add_op(op_rd, make_addr(5'd1, 8'd5, 2'd1), 16'h0000);
      add_op(op_rd, make_addr(5'd3, 8'd5, 2'd0), 16'h0000);
      add_op(op_bad, make_addr(5'd1, 8'd5, 2'd0) | 16'h0001, 16'h0000);  // odd address
      add_op(op_bad, make_addr(5'd1, 8'd5, 2'd0), 16'h0000);  // rd and wr together
      add_op(op_wr, make_addr(5'd31, 8'd255, 2'd3), 16'hffff);
      add_op(op_rd, make_addr(5'd31, 8'd255, 2'd3), 16'h0000);
      add_op(op_rd, make_addr(5'd0, 8'd255, 2'd0), 16'h0000);
   endtask

   // drive one request and hold it until done, or for two cycles if illegal
   task automatic run_op(input op_kind_t kind, input logic [15:0] a, input logic [15:0] d);
      logic [7:0]  idx;
      logic [4:0]  tag;
      logic        exp_hit;
      logic [15:0] exp_data;
      idx      = a[10:3];
      tag      = a[15:11];
      exp_hit  = shadow_valid[idx] && (shadow_tag[idx] == tag);
      exp_data = shadow_mem[a[15:1]];
      addr     = a;
      data_in  = d;
      rd       = (kind != op_wr);
      wr       = (kind == op_wr) || (kind == op_bad && !a[0]);
      if (kind == op_bad) begin
         repeat (2) begin
            @(negedge clk);
            checks++;
            if (err !== 1'b1) begin
               errors++;
               $display("FAILED: err = %h, expected 1 (addr %h)", err, a);
            end
            if (done !== 1'b0) begin
               errors++;
               $display("FAILED: done = %h, expected 0 on illegal request (addr %h)", done, a);
            end
         end
      end else begin
         @(negedge clk);
         if (done !== 1'b1 && stall !== 1'b0) begin
            errors++;
            $display("FAILED: stall = %h, expected 0 in request cycle (addr %h)", stall, a);
         end
         while (done !== 1'b1) begin
            @(negedge clk);
            if (done !== 1'b1 && stall !== 1'b1) begin
               errors++;
               $display("FAILED: stall = %h, expected 1 during miss (addr %h)", stall, a);
            end
         end
         checks++;
         if (cache_hit !== exp_hit) begin
            errors++;
            $display("FAILED: cache_hit = %h, expected %h (addr %h)", cache_hit, exp_hit, a);
         end
         if (err !== 1'b0) begin
            errors++;
            $display("FAILED: err = %h, expected 0 (addr %h)", err, a);
         end
         if (kind == op_rd && data_out !== exp_data) begin
            errors++;
            $display("FAILED: data_out = %h, expected %h (addr %h)", data_out, exp_data, a);
         end
         if (kind == op_wr)
            shadow_mem[a[15:1]] = d;
         shadow_valid[idx] = 1'b1;  // line now holds this tag
         shadow_tag[idx]   = tag;
      end
      @(posedge clk);
      #drive_delay;
      rd = 1'b0;
      wr = 1'b0;
   endtask

   // a few tags and indexes so conflicts and hits both show up
   task automatic run_random_op();
      logic [31:0] r;
      logic [7:0]  idx;
      logic [15:0] d;
      r = $random(seed);
      d = 16'($random(seed));
      case (r[3:2])
         2'd0:    idx = 8'h00;
         2'd1:    idx = 8'h05;
         2'd2:    idx = 8'h09;
         default: idx = 8'hff;
      endcase
      run_op(r[6] ? op_wr : op_rd, make_addr({3'b000, r[1:0]}, idx, r[5:4]), d);
   endtask

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      rd          = 1'b0;
      wr          = 1'b0;
      addr        = '0;
      data_in     = '0;
      errors      = 0;
      checks      = 0;
      seed        = 59971;
      table_ready = 1'b0;
      for (int i = 0; i < 32768; i++)
         shadow_mem[i] = '0;
      for (int i = 0; i < 256; i++) begin
         shadow_tag[i]   = '0;
         shadow_valid[i] = 1'b0;
      end
      build_table();
      table_ready = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      #drive_delay;
      rst_n = 1'b1;
      @(negedge clk);
      checks++;
      if (stall !== 1'b0 || done !== 1'b0) begin
         errors++;
         $display("FAILED: stall/done = %h/%h after reset, expected 0/0", stall, done);
      end
      @(posedge clk);
      #drive_delay;
      for (int i = 0; i < tbl_kind.size(); i++)
         run_op(tbl_kind[i], tbl_addr[i], tbl_data[i]);
      for (int i = 0; i < n_random; i++)
         run_random_op();
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   // watchdog sized from the number of operations
   initial begin
      int limit;
      wait (table_ready);
      limit = (tbl_kind.size() + n_random) * cycles_per_op + reset_cycles;
      repeat (limit) @(posedge clk);
      $display("timeout: request not completed within %0d cycles", limit);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
common/mem_pkg.sv
cache/cache_array.sv
cache/cache_ctrl.sv
memory/four_bank_mem.sv
design/mem_system.sv
bench/mem_system_checker.sv
bench/mem_system_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := mem_system_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Test completed successfully
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
